// ==== compile.f ====
+incdir+logic
logic/cmd_pkg.sv
logic/cmd_links.sv
logic/msg_parser.sv
logic/system_unit.sv
logic/gpio_unit.sv
logic/unit_dispatch.sv
logic/rsp_encoder.sv
logic/command_top.sv
test/command_properties.sv
test/command_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the command engine testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module command_tb -f compile.f \
	--Mdir obj_dir -o command_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/command_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

// ==== test/command_tb.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

module command_tb;

	localparam int N_ENTRIES = 22;
	localparam int ENTRY_CYCLES = 200;
	localparam int CYCLE_LIMIT = ENTRY_CYCLES * N_ENTRIES;

	typedef struct {
		int id;
		int a0;
		int a1;
		int kind;
		logic [7:0] gpio;
		bit wait_done;
		int pct;
	} entry_t;

	typedef struct {
		int kind;
		logic [5:0][7:0] bytes;
		int len;
		logic [7:0] gpio;
		bit gchk;
		cmd_pkg::arg_t base;
		int t0;
	} expect_t;

	logic clk;
	logic rst_n;
	logic [7:0] msg_data;
	logic msg_ready;
	logic send_ring_full;
	wire msg_rd_en;
	wire [7:0] send_ring_data;
	wire send_ring_wr_en;
	wire [7:0] send_len_data;
	wire send_len_wr_en;
	wire [`CMD_NGPIO-1:0] gpio;

	entry_t tbl [N_ENTRIES];
	logic [7:0] src_q[$];
	logic [7:0] got_q[$];
	expect_t exp_q[$];
	int cycles;
	int full_pct;
	int errors;
	cmd_pkg::arg_t sync_base;
	int sync_cycle;

	command_top command_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_len_data(send_len_data),
		.send_len_wr_en(send_len_wr_en),
		.gpio(gpio)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==============================
	// Reporting and compare tasks
	// ==============================
	task automatic stop_fail(input string what);
		errors++;
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
			stop_fail($sformatf("error at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_len(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_fail($sformatf("error at %0t: send_len_data got %0d expected %0d",
				$time, got, exp));
	endtask

	task automatic check_gpio(input logic [`CMD_NGPIO-1:0] got,
		input logic [`CMD_NGPIO-1:0] exp);
		if (got !== exp)
			stop_fail($sformatf("error at %0t: gpio got %h expected %h", $time, got, exp));
	endtask

	task automatic check_time(input cmd_pkg::arg_t got, input cmd_pkg::arg_t lo,
		input cmd_pkg::arg_t hi);
		if (got < lo || got > hi)
			stop_fail($sformatf("error at %0t: get_time value got %0d expected %0d..%0d",
				$time, got, lo, hi));
	endtask

	// ==============================
	// VLQ model
	// ==============================
	function automatic int vlq_encode(input int v, output logic [4:0][7:0] b);
		int n;
		int grp;
		b = '0;
		if (v >= -32 && v < 96)
			n = 1;
		else if (v >= -4096 && v < 12288)
			n = 2;
		else if (v >= -524288 && v < 1572864)
			n = 3;
		else if (v >= -67108864 && v < 201326592)
			n = 4;
		else
			n = 5;
		for (int i = 0; i < n; i++) begin
			grp = (v >>> (7 * (n - 1 - i))) & 127;
			b[i] = 8'(grp) | ((i < n - 1) ? 8'h80 : 8'h00);
		end
		return n;
	endfunction

	// Decodes the word that starts at got_q[1].
	function automatic cmd_pkg::arg_t vlq_decode(output int n);
		cmd_pkg::arg_t v;
		v = (got_q[1][6] && got_q[1][5]) ? '1 : '0;
		n = 0;
		do begin
			n++;
			v = {v[24:0], got_q[n][6:0]};
		end while (got_q[n][7] && n < got_q.size() - 1);
		return v;
	endfunction

	// ==============================
	// Byte source and ring sink
	// ==============================
	always @(negedge clk) begin
		if (rst_n) begin
			if (msg_rd_en) begin
				void'(src_q.pop_front());
				if (src_q.size() > 0)
					msg_data <= src_q[0];
			end else begin
				msg_ready <= (src_q.size() > 0);
				if (src_q.size() > 0)
					msg_data <= src_q[0];
			end
			send_ring_full <= ($urandom_range(99) < full_pct);
		end
	end

	task automatic finish_response();
		expect_t e;
		logic [4:0][7:0] b;
		cmd_pkg::arg_t v;
		int n;
		if (exp_q.size() == 0)
			stop_fail("A response was written while none was expected.");
		e = exp_q.pop_front();
		if (e.kind == 2) begin
			if (got_q.size() < 2)
				stop_fail("The get_time response has no parameter bytes.");
			v = vlq_decode(n);
			check_time(v, e.base, e.base + cmd_pkg::arg_t'(cycles - e.t0));
			n = vlq_encode(int'(v), b);
			e.bytes = {b, 8'd1};
			e.len = n + 1;
		end
		check_len(send_len_data, 8'(e.len));
		if (got_q.size() != e.len)
			stop_fail($sformatf("Response carried %0d bytes, but %0d were expected.",
				got_q.size(), e.len));
		for (int i = 0; i < e.len; i++)
			check_byte("send_ring_data", got_q[i], e.bytes[i]);
		if (e.gchk)
			check_gpio(gpio, e.gpio);
		got_q.delete();
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (send_len_wr_en)
				finish_response();
			if (send_ring_wr_en)
				got_q.push_back(send_ring_data);
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
			if (cycles > CYCLE_LIMIT)
				stop_fail("Timeout: the run exceeded its cycle limit.");
		end
	end

	// ==============================
	// Stimulus table
	// ==============================
	task automatic build_table();
		tbl[0] = '{0, 0, 0, 1, 8'h00, 1'b1, 20};
		tbl[1] = '{15, 1, 1, 0, 8'h02, 1'b1, 20};
		tbl[2] = '{15, -3, -1, 0, 8'h22, 1'b1, 20};
		tbl[3] = '{15, 130, 12289, 0, 8'h26, 1'b1, 20};
		tbl[4] = '{15, 1, 0, 0, 8'h24, 1'b1, 20};
		tbl[5] = '{0, 0, 0, 1, 8'h24, 1'b1, 20};
		tbl[6] = '{1, 1000000, 0, 0, 8'h24, 1'b1, 20};
		tbl[7] = '{2, 0, 0, 2, 8'h24, 1'b1, 20};
		tbl[8] = '{1, 300000000, 0, 0, 8'h24, 1'b1, 30};
		tbl[9] = '{2, 0, 0, 2, 8'h24, 1'b1, 30};
		// Back to back under heavy ring back-pressure.
		tbl[10] = '{0, 0, 0, 1, 8'h24, 1'b0, 85};
		tbl[11] = '{7, 0, 0, 0, 8'h24, 1'b0, 85};
		tbl[12] = '{0, 0, 0, 1, 8'h24, 1'b0, 85};
		tbl[13] = '{15, 6, 1, 0, 8'h64, 1'b0, 85};
		tbl[14] = '{200, 0, 0, 0, 8'h64, 1'b0, 85};
		tbl[15] = '{0, 0, 0, 1, 8'h64, 1'b1, 85};
		tbl[16] = '{99, 0, 0, 0, 8'h64, 1'b1, 20};
		tbl[17] = '{0, 0, 0, 1, 8'h64, 1'b1, 20};
		tbl[18] = '{19, 0, 0, 0, 8'h00, 1'b1, 20};
		tbl[19] = '{15, 0, 1, 0, 8'h00, 1'b1, 20};
		tbl[20] = '{15, -3, 201, 0, 8'h00, 1'b1, 20};
		tbl[21] = '{0, 0, 0, 1, 8'h00, 1'b1, 20};
	endtask

	task automatic issue_entry(input entry_t t);
		expect_t e;
		logic [4:0][7:0] b;
		int n;
		full_pct = t.pct;
		if (t.id == 1) begin
			sync_base = cmd_pkg::arg_t'(t.a0);
			sync_cycle = cycles;
		end
		src_q.push_back(8'(t.id));
		// Only sync_time and set_digital_out take arguments.
		if (t.id == 1 || t.id == 15) begin
			n = vlq_encode(t.a0, b);
			for (int i = 0; i < n; i++)
				src_q.push_back(b[i]);
			n = vlq_encode(t.a1, b);
			for (int i = 0; i < n; i++)
				src_q.push_back(b[i]);
		end
		if (t.kind != 0) begin
			e.kind = t.kind;
			n = vlq_encode(int'(`CMD_VERSION), b);
			e.bytes = {b, 8'd0};
			e.len = n + 1;
			e.gpio = t.gpio;
			e.gchk = t.wait_done;
			e.base = sync_base;
			e.t0 = sync_cycle;
			exp_q.push_back(e);
		end
	endtask

	initial begin
		int wait_cnt;
		void'($urandom(62899));
		rst_n = 1'b0;
		msg_data = 8'h00;
		msg_ready = 1'b0;
		send_ring_full = 1'b0;
		cycles = 0;
		full_pct = 0;
		errors = 0;
		sync_base = '0;
		sync_cycle = 0;
		build_table();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < N_ENTRIES; i++) begin
			@(negedge clk);
			issue_entry(tbl[i]);
			if (tbl[i].wait_done) begin
				if (tbl[i].kind != 0) begin
					while (exp_q.size() != 0)
						@(negedge clk);
				end else begin
					wait_cnt = 0;
					while ((src_q.size() != 0 || msg_rd_en || gpio !== tbl[i].gpio) &&
						wait_cnt < ENTRY_CYCLES) begin
						@(negedge clk);
						wait_cnt++;
					end
					check_gpio(gpio, tbl[i].gpio);
				end
			end
		end
		while (exp_q.size() != 0)
			@(negedge clk);
		check_gpio(gpio, tbl[N_ENTRIES-1].gpio);
		if (errors == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("RESULT: FAIL");
			$fatal(1, "errors were found");
		end
	end

endmodule

`default_nettype wire

// ==== test/command_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_properties (
	input wire clk,
	input wire rst_n,
	input wire msg_ready,
	input wire msg_rd_en,
	input wire send_ring_wr_en,
	input wire send_ring_full
);

	// Ring writes only go out when there is room.
	ring_room: assert property (@(posedge clk) disable iff (!rst_n)
		!(send_ring_wr_en && send_ring_full))
		else $error("send_ring_wr_en while send_ring_full");

	rd_single: assert property (@(posedge clk) disable iff (!rst_n)
		msg_rd_en |=> !msg_rd_en)
		else $error("msg_rd_en held for two cycles");

	rd_ready: assert property (@(posedge clk) disable iff (!rst_n)
		msg_rd_en |-> msg_ready)
		else $error("msg_rd_en while msg_ready low");

endmodule

bind command_top command_properties command_properties_i (
	.clk(clk),
	.rst_n(rst_n),
	.msg_ready(msg_ready),
	.msg_rd_en(msg_rd_en),
	.send_ring_wr_en(send_ring_wr_en),
	.send_ring_full(send_ring_full)
);

`default_nettype wire

// ==== logic/command_top.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

module command_top (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output wire msg_rd_en,
	output wire [7:0] send_ring_data,
	output wire send_ring_wr_en,
	input wire send_ring_full,
	output wire [7:0] send_len_data,
	output wire send_len_wr_en,
	output wire [`CMD_NGPIO-1:0] gpio
);

	cmd_link cmd_bus ();
	rsp_link rsp_bus ();

	msg_parser msg_parser_i (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.cmd(cmd_bus)
	);

	unit_dispatch unit_dispatch_i (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd_bus),
		.rsp(rsp_bus),
		.gpio(gpio)
	);

	rsp_encoder rsp_encoder_i (
		.clk(clk),
		.rst_n(rst_n),
		.rsp(rsp_bus),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_len_data(send_len_data),
		.send_len_wr_en(send_len_wr_en)
	);

endmodule

`default_nettype wire

// ==== logic/rsp_encoder.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

module rsp_encoder (
	input wire clk,
	input wire rst_n,
	rsp_link.receiver rsp,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input wire send_ring_full,
	output logic [7:0] send_len_data,
	output logic send_len_wr_en
);

	localparam int VLQ_W = $clog2(`CMD_VLQ_BYTES + 1);

	typedef enum logic [1:0] {
		E_IDLE,
		E_ID,
		E_PARAM
	} state_t;

	state_t state;
	logic accept;
	logic last_byte;
	cmd_pkg::rsp_id_t rsp_id;
	cmd_pkg::param_cnt_t left_params;
	cmd_pkg::arg_t [`CMD_MAX_PARAMS-1:0] params;
	logic [VLQ_W-1:0] cur_len;
	logic [VLQ_W-1:0] sent;
	logic [7:0] count;
	logic [7:0] next_count;
	logic [34:0] shifted;

	// Shortest form that still decodes back to the same signed value.
	function automatic logic [VLQ_W-1:0] vlq_len(input cmd_pkg::arg_t v);
		logic signed [31:0] s;
		s = v;
		if (s >= -32 && s < 96)
			return VLQ_W'(1);
		if (s >= -4096 && s < 12288)
			return VLQ_W'(2);
		if (s >= -524288 && s < 1572864)
			return VLQ_W'(3);
		if (s >= -67108864 && s < 201326592)
			return VLQ_W'(4);
		return VLQ_W'(`CMD_VLQ_BYTES);
	endfunction

	assign accept = (state == E_IDLE) && rsp.req && !rsp.ack;
	assign cur_len = vlq_len(params[0]);
	assign last_byte = (sent == cur_len - 1'b1);
	assign shifted = {{3{params[0][31]}}, params[0]} >> (7 * (cur_len - 1'b1 - sent));
	assign next_count = (state == E_ID) ? 8'd1 : count + 8'd1;

	assign send_ring_wr_en = (state != E_IDLE) && !send_ring_full;
	assign send_ring_data = (state == E_ID) ? rsp_id : {~last_byte, shifted[6:0]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= E_IDLE;
			rsp.ack <= 1'b0;
			send_len_wr_en <= 1'b0;
		end else begin
			send_len_wr_en <= 1'b0;
			if (rsp.ack && !rsp.req)
				rsp.ack <= 1'b0;
			if (accept) begin
				rsp.ack <= 1'b1;
				state <= E_ID;
			end else if (send_ring_wr_en) begin
				// Length goes out the cycle after the final byte.
				if ((state == E_ID && left_params == '0) ||
				    (state == E_PARAM && last_byte && left_params == 1'b1)) begin
					send_len_wr_en <= 1'b1;
					state <= E_IDLE;
				end else begin
					state <= E_PARAM;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_id <= rsp.rsp_id;
			params <= rsp.params;
			left_params <= rsp.nparams;
		end
		if (send_ring_wr_en) begin
			count <= next_count;
			send_len_data <= next_count;
			if (state == E_ID || last_byte)
				sent <= '0;
			else
				sent <= sent + 1'b1;
			if (state == E_PARAM && last_byte) begin
				for (int i = 0; i < `CMD_MAX_PARAMS - 1; i++)
					params[i] <= params[i + 1];
				left_params <= left_params - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/unit_dispatch.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

module unit_dispatch (
	input wire clk,
	input wire rst_n,
	cmd_link.receiver cmd,
	rsp_link.sender rsp,
	output wire [`CMD_NGPIO-1:0] gpio
);

	typedef enum logic [1:0] {
		D_IDLE,
		D_RUN,
		D_RSP,
		D_DONE
	} state_t;

	state_t state;
	logic start;
	logic rsp_load;
	logic shutdown;
	cmd_pkg::arg_t sys_result;

	// Units act on the edge after req, result is ready one cycle later.
	assign start = (state == D_IDLE) && cmd.req && !cmd.ack &&
		(cmd.unit != cmd_pkg::UNIT_NONE);
	assign rsp_load = (state == D_RUN) && cmd.has_rsp && !rsp.ack;

	system_unit system_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start && (cmd.unit == cmd_pkg::UNIT_SYSTEM)),
		.cmd(cmd.cmd),
		.args(cmd.args),
		.result(sys_result),
		.shutdown(shutdown)
	);

	gpio_unit gpio_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start && (cmd.unit == cmd_pkg::UNIT_GPIO)),
		.args(cmd.args),
		.shutdown(shutdown),
		.gpio(gpio)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= D_IDLE;
			cmd.ack <= 1'b0;
			rsp.req <= 1'b0;
		end else begin
			case (state)
				D_IDLE: begin
					if (start) begin
						state <= D_RUN;
					end else if (cmd.req && !cmd.ack) begin
						cmd.ack <= 1'b1;
						state <= D_DONE;
					end
				end
				D_RUN: begin
					if (!cmd.has_rsp) begin
						cmd.ack <= 1'b1;
						state <= D_DONE;
					end else if (rsp_load) begin
						rsp.req <= 1'b1;
						state <= D_RSP;
					end
				end
				// Command is only released once the encoder holds its record.
				D_RSP: begin
					if (rsp.ack) begin
						rsp.req <= 1'b0;
						cmd.ack <= 1'b1;
						state <= D_DONE;
					end
				end
				default: begin
					if (!cmd.req) begin
						cmd.ack <= 1'b0;
						state <= D_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_load) begin
			rsp.rsp_id <= (cmd.cmd == cmd_pkg::CMD_GET_TIME) ?
				cmd_pkg::RSP_GET_TIME : cmd_pkg::RSP_GET_VERSION;
			rsp.nparams <= cmd_pkg::param_cnt_t'(1);
			rsp.params <= '0;
			rsp.params[0] <= sys_result;
		end
	end

endmodule

`default_nettype wire

// ==== logic/gpio_unit.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

module gpio_unit (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire cmd_pkg::arg_t [`CMD_MAX_ARGS-1:0] args,
	input wire shutdown,
	output logic [`CMD_NGPIO-1:0] gpio
);

	localparam int SEL_W = (`CMD_NGPIO > 1) ? $clog2(`CMD_NGPIO) : 1;

	logic [SEL_W-1:0] sel;

	// Channel number wraps on the output count.
	assign sel = SEL_W'(args[0] % `CMD_NGPIO);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gpio <= '0;
		end else if (shutdown) begin
			gpio <= '0;
		end else if (start) begin
			gpio[sel] <= args[1][0];
		end
	end

endmodule

`default_nettype wire

// ==== logic/system_unit.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

module system_unit (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire cmd_pkg::cmd_id_t cmd,
	input wire cmd_pkg::arg_t [`CMD_MAX_ARGS-1:0] args,
	output cmd_pkg::arg_t result,
	output logic shutdown
);

	cmd_pkg::arg_t time_cnt;

	// Free running clock count, arg 1 of sync_time is the high word and not kept.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			time_cnt <= '0;
			shutdown <= 1'b0;
		end else begin
			if (start && cmd == cmd_pkg::CMD_SYNC_TIME)
				time_cnt <= args[0];
			else
				time_cnt <= time_cnt + 1'b1;
			// Sticky until the next reset.
			if (start && cmd == cmd_pkg::CMD_SHUTDOWN)
				shutdown <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			case (cmd)
				cmd_pkg::CMD_GET_VERSION: result <= `CMD_VERSION;
				cmd_pkg::CMD_GET_TIME: result <= time_cnt;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/msg_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_parser (
	input wire clk,
	input wire rst_n,
	input wire [7:0] msg_data,
	input wire msg_ready,
	output logic msg_rd_en,
	cmd_link.sender cmd
);

	typedef enum logic {
		ST_ID,
		ST_ARG
	} state_t;

	state_t state;
	logic first;
	logic pending;
	logic take;
	logic last_arg;
	cmd_pkg::cmd_desc_t desc;
	cmd_pkg::arg_cnt_t nargs;
	logic [cmd_pkg::ARG_IDX_W-1:0] arg_idx;
	cmd_pkg::arg_t acc;
	cmd_pkg::arg_t value;

	// A byte is taken at the edge where rd_en rises, never two cycles running.
	assign take = msg_ready && !msg_rd_en && !pending;
	assign desc = cmd_pkg::cmd_table(msg_data);
	assign last_arg = (cmd_pkg::arg_cnt_t'(arg_idx) + 1'b1 == nargs);

	// First VLQ byte with bits 6:5 set starts a negative value.
	always_comb begin
		if (first)
			value = {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
		else
			value = {acc[24:0], msg_data[6:0]};
	end

	// ==============================
	// Control and handshake
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_ID;
			first <= 1'b1;
			pending <= 1'b0;
			msg_rd_en <= 1'b0;
			cmd.req <= 1'b0;
		end else begin
			msg_rd_en <= take;
			if (take) begin
				if (state == ST_ID) begin
					if (desc.nargs == '0) begin
						pending <= 1'b1;
					end else begin
						state <= ST_ARG;
						first <= 1'b1;
					end
				end else if (msg_data[7]) begin
					first <= 1'b0;
				end else begin
					first <= 1'b1;
					if (last_arg) begin
						state <= ST_ID;
						pending <= 1'b1;
					end
				end
			end
			// Wait for the previous ack to drop before the next req.
			if (pending && !cmd.req && !cmd.ack)
				cmd.req <= 1'b1;
			if (cmd.req && cmd.ack) begin
				cmd.req <= 1'b0;
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (state == ST_ID) begin
				cmd.cmd <= cmd_pkg::cmd_id_t'(msg_data);
				cmd.unit <= desc.unit;
				cmd.has_rsp <= desc.has_rsp;
				nargs <= desc.nargs;
				arg_idx <= '0;
			end else if (msg_data[7]) begin
				acc <= value;
			end else begin
				cmd.args[arg_idx] <= value;
				arg_idx <= arg_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/cmd_links.sv ====
`timescale 1ns/1ps
`include "cmd_settings.svh"
`default_nettype none

// Parsed command, parser to dispatcher.
interface cmd_link;
	logic req;
	logic ack;
	cmd_pkg::cmd_id_t cmd;
	cmd_pkg::unit_t unit;
	logic has_rsp;
	cmd_pkg::arg_t [`CMD_MAX_ARGS-1:0] args;

	modport sender (output req, cmd, unit, has_rsp, args, input ack);
	modport receiver (input req, cmd, unit, has_rsp, args, output ack);
endinterface

// Response record, dispatcher to encoder.
interface rsp_link;
	logic req;
	logic ack;
	cmd_pkg::rsp_id_t rsp_id;
	cmd_pkg::param_cnt_t nparams;
	cmd_pkg::arg_t [`CMD_MAX_PARAMS-1:0] params;

	modport sender (output req, rsp_id, nparams, params, input ack);
	modport receiver (input req, rsp_id, nparams, params, output ack);
endinterface

`default_nettype wire

// ==== logic/cmd_pkg.sv ====
`include "cmd_settings.svh"
`default_nettype none

package cmd_pkg;

	localparam int ARG_CNT_W = $clog2(`CMD_MAX_ARGS + 1);
	localparam int ARG_IDX_W = (`CMD_MAX_ARGS > 1) ? $clog2(`CMD_MAX_ARGS) : 1;
	localparam int PARAM_CNT_W = $clog2(`CMD_MAX_PARAMS + 1);

	typedef logic [31:0] arg_t;
	typedef logic [ARG_CNT_W-1:0] arg_cnt_t;
	typedef logic [PARAM_CNT_W-1:0] param_cnt_t;

	typedef enum logic [7:0] {
		CMD_GET_VERSION     = 8'd0,
		CMD_SYNC_TIME       = 8'd1,
		CMD_GET_TIME        = 8'd2,
		CMD_SET_DIGITAL_OUT = 8'd15,
		CMD_SHUTDOWN        = 8'd19
	} cmd_id_t;

	typedef enum logic [1:0] {
		UNIT_NONE   = 2'd0,
		UNIT_SYSTEM = 2'd1,
		UNIT_GPIO   = 2'd2
	} unit_t;

	typedef enum logic [7:0] {
		RSP_GET_VERSION = 8'd0,
		RSP_GET_TIME    = 8'd1
	} rsp_id_t;

	typedef struct packed {
		unit_t unit;
		arg_cnt_t nargs;
		logic has_rsp;
	} cmd_desc_t;

	// Ids missing here fall through to unit none with no arguments.
	function automatic cmd_desc_t cmd_table(input logic [7:0] id);
		cmd_desc_t desc;
		desc = '{unit: UNIT_NONE, nargs: arg_cnt_t'(0), has_rsp: 1'b0};
		case (id)
			CMD_GET_VERSION:     desc = '{UNIT_SYSTEM, arg_cnt_t'(0), 1'b1};
			CMD_SYNC_TIME:       desc = '{UNIT_SYSTEM, arg_cnt_t'(2), 1'b0};
			CMD_GET_TIME:        desc = '{UNIT_SYSTEM, arg_cnt_t'(0), 1'b1};
			CMD_SET_DIGITAL_OUT: desc = '{UNIT_GPIO, arg_cnt_t'(2), 1'b0};
			CMD_SHUTDOWN:        desc = '{UNIT_SYSTEM, arg_cnt_t'(0), 1'b0};
			default: ;
		endcase
		return desc;
	endfunction

endpackage

`default_nettype wire

// ==== logic/cmd_settings.svh ====
`ifndef CMD_SETTINGS_SVH
`define CMD_SETTINGS_SVH
`default_nettype none

// Most decoded arguments per command.
`define CMD_MAX_ARGS 2

// Most parameters in one response.
`define CMD_MAX_PARAMS 1

// Value returned by get_version.
`define CMD_VERSION 32'h00010203

`define CMD_NGPIO 8

// Longest VLQ form of a 32-bit word.
`define CMD_VLQ_BYTES 5

`default_nettype wire
`endif
